// ==== design/bbox_clamp.sv ====
`timescale 1ns/1ps

module bbox_clamp (
    input  raster_fixed_pkg::coord_t i_v0 [2],
    input  raster_fixed_pkg::coord_t i_v1 [2],
    input  raster_fixed_pkg::coord_t i_v2 [2],
    output raster_fixed_pkg::coord_t o_tl [2],
    output raster_fixed_pkg::coord_t o_br [2],
    output logic                     o_valid
);
    import raster_fixed_pkg::*;
    import raster_setup_pkg::*;

    function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // Limit to [0, hi]
    function automatic coord_t clamp(input coord_t v, input coord_t hi);
        if (v < 0) begin
            return '0;
        end else if (v > hi) begin
            return hi;
        end
        return v;
    endfunction

    coord_t min_x;
    coord_t min_y;
    coord_t max_x;
    coord_t max_y;

    always_comb begin
        min_x = min3(i_v0[AXIS_X], i_v1[AXIS_X], i_v2[AXIS_X]);
        max_x = max3(i_v0[AXIS_X], i_v1[AXIS_X], i_v2[AXIS_X]);
        min_y = min3(i_v0[AXIS_Y], i_v1[AXIS_Y], i_v2[AXIS_Y]);
        max_y = max3(i_v0[AXIS_Y], i_v1[AXIS_Y], i_v2[AXIS_Y]);

        o_tl[AXIS_X] = clamp(min_x, SCREEN_MAX_X);
        o_tl[AXIS_Y] = clamp(min_y, SCREEN_MAX_Y);
        o_br[AXIS_X] = clamp(max_x, SCREEN_MAX_X);
        o_br[AXIS_Y] = clamp(max_y, SCREEN_MAX_Y);

        // Empty once fully clamped off screen
        o_valid = (o_tl[AXIS_X] < o_br[AXIS_X]) && (o_tl[AXIS_Y] < o_br[AXIS_Y]);
    end

endmodule

// ==== design/edge_function_unit.sv ====
`timescale 1ns/1ps
`include "raster_params.svh"

module edge_function_unit (
    input  raster_fixed_pkg::coord_t i_a [2],
    input  raster_fixed_pkg::coord_t i_b [2],
    input  raster_fixed_pkg::coord_t i_p [2],
    output raster_fixed_pkg::area_t  o_value,
    output raster_fixed_pkg::area_t  o_delta [2]
);
    import raster_fixed_pkg::*;
    import raster_setup_pkg::*;

    // Product has twice the coordinate fraction bits
    localparam int VALUE_SHIFT = 2 * `RASTER_FRAC_BITS - `RASTER_AREA_FRAC_BITS;
    localparam int STEP_SHIFT  = `RASTER_FRAC_BITS - `RASTER_AREA_FRAC_BITS;
    localparam prod_t  VALUE_HALF = prod_t'(1) <<< (VALUE_SHIFT - 1);
    localparam coord_t STEP_HALF  = coord_t'(1) <<< (STEP_SHIFT - 1);

    coord_t edge_dx;
    coord_t edge_dy;
    coord_t point_dx;
    coord_t point_dy;
    prod_t  product;
    prod_t  product_rnd;
    coord_t step [2];
    coord_t step_rnd [2];

    always_comb begin
        edge_dx  = i_b[AXIS_X] - i_a[AXIS_X];
        edge_dy  = i_b[AXIS_Y] - i_a[AXIS_Y];
        point_dx = i_p[AXIS_X] - i_a[AXIS_X];
        point_dy = i_p[AXIS_Y] - i_a[AXIS_Y];

        product = prod_t'(point_dx) * prod_t'(edge_dy) - prod_t'(point_dy) * prod_t'(edge_dx);
        // Round half up, keep low word of the shifted value
        product_rnd = product + VALUE_HALF;
        o_value     = product_rnd[VALUE_SHIFT +: `RASTER_DATA_W];

        // Per-pixel steps along x and y
        step[AXIS_X] = edge_dy;
        step[AXIS_Y] = -edge_dx;
        for (int ax = AXIS_X; ax <= AXIS_Y; ax++) begin
            step_rnd[ax] = step[ax] + STEP_HALF;
            o_delta[ax]  = area_t'(step_rnd[ax] >>> STEP_SHIFT);
        end
    end

endmodule

// ==== design/raster_fixed_pkg.sv ====
`include "raster_params.svh"

package raster_fixed_pkg;

    // Signed Q16.16 screen-space coordinate
    typedef logic signed [`RASTER_DATA_W-1:0] coord_t;

    // Signed Q28.4 area, edge value or edge step
    typedef logic signed [`RASTER_DATA_W-1:0] area_t;

    // Full edge-function product before rounding
    typedef logic signed [2*`RASTER_DATA_W-1:0] prod_t;

    // Screen limits in coordinate format
    localparam coord_t SCREEN_MAX_X =
        coord_t'(`RASTER_SCREEN_W * (1 << `RASTER_FRAC_BITS));
    localparam coord_t SCREEN_MAX_Y =
        coord_t'(`RASTER_SCREEN_H * (1 << `RASTER_FRAC_BITS));

endpackage

// ==== design/raster_params.svh ====
`ifndef RASTER_PARAMS_SVH
`define RASTER_PARAMS_SVH

// Coordinate and result word width
`define RASTER_DATA_W 32

// Coordinates are Q16.16
`define RASTER_FRAC_BITS 16

// Areas, edge values and edge steps are Q28.4
`define RASTER_AREA_FRAC_BITS 4

// Screen size in pixels
`define RASTER_SCREEN_W 640
`define RASTER_SCREEN_H 360

`endif

// ==== design/raster_setup_pkg.sv ====
package raster_setup_pkg;

    // Setup sequencer states
    typedef enum logic [2:0] {
        IDLE,
        AREA,
        EDGE0,
        EDGE1,
        EDGE2,
        DONE
    } setup_state_t;

    // Index names for x/y coordinate pairs
    localparam int AXIS_X = 0;
    localparam int AXIS_Y = 1;

endpackage

// ==== design/setup_sequencer.sv ====
`timescale 1ns/1ps

module setup_sequencer (
    input  logic                     clk,
    input  logic                     rstn,
    input  raster_fixed_pkg::coord_t i_v0 [2],
    input  raster_fixed_pkg::coord_t i_v1 [2],
    input  raster_fixed_pkg::coord_t i_v2 [2],
    input  logic                     i_dv,
    input  logic                     i_ready,
    input  raster_fixed_pkg::coord_t i_bb_tl [2],
    input  raster_fixed_pkg::coord_t i_bb_br [2],
    input  logic                     i_bb_valid,
    input  raster_fixed_pkg::area_t  i_edge_value,
    input  raster_fixed_pkg::area_t  i_edge_delta [2],
    output logic                     o_ready,
    output raster_fixed_pkg::coord_t o_bb_v0 [2],
    output raster_fixed_pkg::coord_t o_bb_v1 [2],
    output raster_fixed_pkg::coord_t o_bb_v2 [2],
    output raster_fixed_pkg::coord_t o_edge_a [2],
    output raster_fixed_pkg::coord_t o_edge_b [2],
    output raster_fixed_pkg::coord_t o_edge_p [2],
    output raster_fixed_pkg::coord_t o_bb_tl [2],
    output raster_fixed_pkg::coord_t o_bb_br [2],
    output raster_fixed_pkg::area_t  o_edge_val0,
    output raster_fixed_pkg::area_t  o_edge_val1,
    output raster_fixed_pkg::area_t  o_edge_val2,
    output raster_fixed_pkg::area_t  o_edge_delta0 [2],
    output raster_fixed_pkg::area_t  o_edge_delta1 [2],
    output raster_fixed_pkg::area_t  o_edge_delta2 [2],
    output raster_fixed_pkg::area_t  o_area,
    output logic                     o_dv,
    output logic                     o_culled
);
    import raster_fixed_pkg::*;
    import raster_setup_pkg::*;

    // One LSB of Q28.4
    localparam area_t MIN_AREA = area_t'(1);

    setup_state_t state;
    setup_state_t state_next;

    coord_t r_v0 [2];
    coord_t r_v1 [2];
    coord_t r_v2 [2];
    coord_t r_bb_tl [2];
    coord_t r_bb_br [2];
    logic   r_bb_valid;
    area_t  r_area;
    area_t  r_edge_val [3];
    area_t  r_edge_delta [3][2];
    logic   accept;
    logic   cull;

    assign o_ready = (state == IDLE);
    assign accept  = o_ready && i_dv;
    assign cull    = (r_area <= MIN_AREA) || !r_bb_valid;

    assign o_bb_v0 = r_v0;
    assign o_bb_v1 = r_v1;
    assign o_bb_v2 = r_v2;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_next = AREA;
                end
            end
            AREA:  state_next = EDGE0;
            EDGE0: state_next = cull ? IDLE : EDGE1;
            EDGE1: state_next = EDGE2;
            EDGE2: state_next = DONE;
            DONE: begin
                if (i_ready) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    // Shared edge unit, area first, then edges at box top-left
    always_comb begin
        o_edge_a = r_v0;
        o_edge_b = r_v1;
        o_edge_p = r_bb_tl;
        case (state)
            AREA: o_edge_p = r_v2;
            EDGE1: begin
                o_edge_a = r_v1;
                o_edge_b = r_v2;
            end
            EDGE2: begin
                o_edge_a = r_v2;
                o_edge_b = r_v0;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            r_v0 <= i_v0;
            r_v1 <= i_v1;
            r_v2 <= i_v2;
        end
        case (state)
            AREA: begin
                r_area     <= i_edge_value;
                r_bb_tl    <= i_bb_tl;
                r_bb_br    <= i_bb_br;
                r_bb_valid <= i_bb_valid;
            end
            EDGE0: begin
                r_edge_val[0]   <= i_edge_value;
                r_edge_delta[0] <= i_edge_delta;
            end
            EDGE1: begin
                r_edge_val[1]   <= i_edge_value;
                r_edge_delta[1] <= i_edge_delta;
            end
            EDGE2: begin
                r_edge_val[2]   <= i_edge_value;
                r_edge_delta[2] <= i_edge_delta;
            end
            default: begin
            end
        endcase
    end

    // Output registers, held until the next delivery
    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_dv          <= 1'b0;
            o_culled      <= 1'b0;
            o_bb_tl       <= '{default: '0};
            o_bb_br       <= '{default: '0};
            o_edge_val0   <= '0;
            o_edge_val1   <= '0;
            o_edge_val2   <= '0;
            o_edge_delta0 <= '{default: '0};
            o_edge_delta1 <= '{default: '0};
            o_edge_delta2 <= '{default: '0};
            o_area        <= '0;
        end else begin
            o_dv     <= 1'b0;
            o_culled <= (state == EDGE0) && cull;
            if (state == DONE && i_ready) begin
                o_dv          <= 1'b1;
                o_bb_tl       <= r_bb_tl;
                o_bb_br       <= r_bb_br;
                o_edge_val0   <= r_edge_val[0];
                o_edge_val1   <= r_edge_val[1];
                o_edge_val2   <= r_edge_val[2];
                o_edge_delta0 <= r_edge_delta[0];
                o_edge_delta1 <= r_edge_delta[1];
                o_edge_delta2 <= r_edge_delta[2];
                o_area        <= r_area;
            end
        end
    end

    a_dv_culled_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(o_dv && o_culled));

    // Back in IDLE whenever a result is reported
    a_ready_on_result: assert property (@(posedge clk) disable iff (!rstn)
        (o_dv || o_culled) |-> o_ready);

    a_dv_single: assert property (@(posedge clk) disable iff (!rstn)
        o_dv |=> !o_dv);

endmodule

// ==== design/triangle_setup_top.sv ====
`timescale 1ns/1ps

module triangle_setup_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  raster_fixed_pkg::coord_t i_v0 [3],
    input  raster_fixed_pkg::coord_t i_v1 [3],
    input  raster_fixed_pkg::coord_t i_v2 [3],
    input  logic                     i_dv,
    input  logic                     i_ready,
    output logic                     o_ready,
    output raster_fixed_pkg::coord_t o_bb_tl [2],
    output raster_fixed_pkg::coord_t o_bb_br [2],
    output raster_fixed_pkg::area_t  o_edge_val0,
    output raster_fixed_pkg::area_t  o_edge_val1,
    output raster_fixed_pkg::area_t  o_edge_val2,
    output raster_fixed_pkg::area_t  o_edge_delta0 [2],
    output raster_fixed_pkg::area_t  o_edge_delta1 [2],
    output raster_fixed_pkg::area_t  o_edge_delta2 [2],
    output raster_fixed_pkg::area_t  o_area,
    output logic                     o_dv,
    output logic                     o_culled
);
    import raster_fixed_pkg::*;
    import raster_setup_pkg::*;

    // Only x and y take part in setup
    coord_t v0_xy [2];
    coord_t v1_xy [2];
    coord_t v2_xy [2];
    coord_t bb_v0 [2];
    coord_t bb_v1 [2];
    coord_t bb_v2 [2];
    coord_t bb_tl [2];
    coord_t bb_br [2];
    logic   bb_valid;
    coord_t edge_a [2];
    coord_t edge_b [2];
    coord_t edge_p [2];
    area_t  edge_value;
    area_t  edge_delta [2];

    assign v0_xy[AXIS_X] = i_v0[AXIS_X];
    assign v0_xy[AXIS_Y] = i_v0[AXIS_Y];
    assign v1_xy[AXIS_X] = i_v1[AXIS_X];
    assign v1_xy[AXIS_Y] = i_v1[AXIS_Y];
    assign v2_xy[AXIS_X] = i_v2[AXIS_X];
    assign v2_xy[AXIS_Y] = i_v2[AXIS_Y];

    setup_sequencer setup_sequencer_i (
        .clk           (clk),
        .rstn          (rstn),
        .i_v0          (v0_xy),
        .i_v1          (v1_xy),
        .i_v2          (v2_xy),
        .i_dv          (i_dv),
        .i_ready       (i_ready),
        .i_bb_tl       (bb_tl),
        .i_bb_br       (bb_br),
        .i_bb_valid    (bb_valid),
        .i_edge_value  (edge_value),
        .i_edge_delta  (edge_delta),
        .o_ready       (o_ready),
        .o_bb_v0       (bb_v0),
        .o_bb_v1       (bb_v1),
        .o_bb_v2       (bb_v2),
        .o_edge_a      (edge_a),
        .o_edge_b      (edge_b),
        .o_edge_p      (edge_p),
        .o_bb_tl       (o_bb_tl),
        .o_bb_br       (o_bb_br),
        .o_edge_val0   (o_edge_val0),
        .o_edge_val1   (o_edge_val1),
        .o_edge_val2   (o_edge_val2),
        .o_edge_delta0 (o_edge_delta0),
        .o_edge_delta1 (o_edge_delta1),
        .o_edge_delta2 (o_edge_delta2),
        .o_area        (o_area),
        .o_dv          (o_dv),
        .o_culled      (o_culled)
    );

    bbox_clamp bbox_clamp_i (
        .i_v0    (bb_v0),
        .i_v1    (bb_v1),
        .i_v2    (bb_v2),
        .o_tl    (bb_tl),
        .o_br    (bb_br),
        .o_valid (bb_valid)
    );

    edge_function_unit edge_function_unit_i (
        .i_a     (edge_a),
        .i_b     (edge_b),
        .i_p     (edge_p),
        .o_value (edge_value),
        .o_delta (edge_delta)
    );

endmodule

// ==== dv/tb_triangle_setup.sv ====
`timescale 1ns/1ps

module tb_triangle_setup;
    import raster_fixed_pkg::*;
    import raster_setup_pkg::*;

    localparam int NUM_TRIS       = 200;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = NUM_TRIS * 20 + RESET_CYCLES;

    logic   clk;
    logic   rstn;
    coord_t i_v0 [3];
    coord_t i_v1 [3];
    coord_t i_v2 [3];
    logic   i_dv;
    logic   i_ready;
    logic   o_ready;
    coord_t o_bb_tl [2];
    coord_t o_bb_br [2];
    area_t  o_edge_val0;
    area_t  o_edge_val1;
    area_t  o_edge_val2;
    area_t  o_edge_delta0 [2];
    area_t  o_edge_delta1 [2];
    area_t  o_edge_delta2 [2];
    area_t  o_area;
    logic   o_dv;
    logic   o_culled;

    int unsigned lcg_state;
    int          cycle_count = 0;
    longint      vtx [3][2];
    longint      exp_tl [2];
    longint      exp_br [2];
    longint      exp_area;
    longint      exp_val [3];
    longint      exp_delta [3][2];
    logic        exp_culled;

    triangle_setup_top triangle_setup_top_i (
        .clk           (clk),
        .rstn          (rstn),
        .i_v0          (i_v0),
        .i_v1          (i_v1),
        .i_v2          (i_v2),
        .i_dv          (i_dv),
        .i_ready       (i_ready),
        .o_ready       (o_ready),
        .o_bb_tl       (o_bb_tl),
        .o_bb_br       (o_bb_br),
        .o_edge_val0   (o_edge_val0),
        .o_edge_val1   (o_edge_val1),
        .o_edge_val2   (o_edge_val2),
        .o_edge_delta0 (o_edge_delta0),
        .o_edge_delta1 (o_edge_delta1),
        .o_edge_delta2 (o_edge_delta2),
        .o_area        (o_area),
        .o_dv          (o_dv),
        .o_culled      (o_culled)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: the DUT gave no result within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "Timeout");
        end
    end

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;
    endfunction

    // Pixel range -64..703 with a random fraction
    function automatic longint rand_coord();
        longint px;
        px = longint'(next_rand() % 768) - 64;
        return px * 65536 + longint'(next_rand() & 32'hffff);
    endfunction

    function automatic longint clamp_axis(input longint v, input longint hi);
        if (v < 0) begin
            return 0;
        end else if (v > hi) begin
            return hi;
        end
        return v;
    endfunction

    function automatic longint round_step(input longint d);
        return longint'(int'((d + 2048) >>> 12));
    endfunction

    // Edge from vertex a to vertex b, evaluated at (px, py)
    function automatic longint edge_eval(input int a, input int b, input longint px,
                                         input longint py);
        longint prod;
        prod = (px - vtx[a][0]) * (vtx[b][1] - vtx[a][1])
             - (py - vtx[a][1]) * (vtx[b][0] - vtx[a][0]);
        return longint'(int'((prod + (longint'(1) <<< 27)) >>> 28));
    endfunction

    function automatic void compute_model();
        int     i;
        int     ax;
        int     b;
        longint lo;
        longint hi;
        longint lim;
        logic   valid;
        valid = 1'b1;
        for (ax = AXIS_X; ax <= AXIS_Y; ax++) begin
            lo = vtx[0][ax];
            hi = vtx[0][ax];
            for (i = 1; i < 3; i++) begin
                if (vtx[i][ax] < lo) lo = vtx[i][ax];
                if (vtx[i][ax] > hi) hi = vtx[i][ax];
            end
            lim = (ax == AXIS_X) ? longint'(SCREEN_MAX_X) : longint'(SCREEN_MAX_Y);
            exp_tl[ax] = clamp_axis(lo, lim);
            exp_br[ax] = clamp_axis(hi, lim);
            if (exp_tl[ax] >= exp_br[ax]) valid = 1'b0;
        end
        exp_area = edge_eval(0, 1, vtx[2][AXIS_X], vtx[2][AXIS_Y]);
        for (i = 0; i < 3; i++) begin
            b = (i + 1) % 3;
            exp_val[i] = edge_eval(i, b, exp_tl[AXIS_X], exp_tl[AXIS_Y]);
            exp_delta[i][AXIS_X] = round_step(vtx[b][AXIS_Y] - vtx[i][AXIS_Y]);
            exp_delta[i][AXIS_Y] = round_step(-(vtx[b][AXIS_X] - vtx[i][AXIS_X]));
        end
        exp_culled = (exp_area <= 1) || !valid;
    endfunction

    task automatic check_equal(input string what, input longint got, input longint expected);
        if (got != expected) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, expected);
            $display("Simulation failed");
            $fatal(1, "Mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic make_triangle(input int n);
        int i;
        int ax;
        for (i = 0; i < 3; i++) begin
            for (ax = AXIS_X; ax <= AXIS_Y; ax++) begin
                vtx[i][ax] = rand_coord();
            end
        end
        // Every eighth triangle has v2 on the line through v0 and v1
        if (n % 8 == 3) begin
            for (ax = AXIS_X; ax <= AXIS_Y; ax++) begin
                vtx[2][ax] = 2 * vtx[1][ax] - vtx[0][ax];
            end
        end
        for (ax = AXIS_X; ax <= AXIS_Y; ax++) begin
            i_v0[ax] = coord_t'(vtx[0][ax]);
            i_v1[ax] = coord_t'(vtx[1][ax]);
            i_v2[ax] = coord_t'(vtx[2][ax]);
        end
        // z is ignored by the DUT
        i_v0[2] = coord_t'(next_rand());
        i_v1[2] = coord_t'(next_rand());
        i_v2[2] = coord_t'(next_rand());
    endtask

    task automatic check_results();
        check_equal("o_bb_tl.x", o_bb_tl[AXIS_X], exp_tl[AXIS_X]);
        check_equal("o_bb_tl.y", o_bb_tl[AXIS_Y], exp_tl[AXIS_Y]);
        check_equal("o_bb_br.x", o_bb_br[AXIS_X], exp_br[AXIS_X]);
        check_equal("o_bb_br.y", o_bb_br[AXIS_Y], exp_br[AXIS_Y]);
        check_equal("o_area", o_area, exp_area);
        check_equal("o_edge_val0", o_edge_val0, exp_val[0]);
        check_equal("o_edge_val1", o_edge_val1, exp_val[1]);
        check_equal("o_edge_val2", o_edge_val2, exp_val[2]);
        check_equal("o_edge_delta0.x", o_edge_delta0[AXIS_X], exp_delta[0][AXIS_X]);
        check_equal("o_edge_delta0.y", o_edge_delta0[AXIS_Y], exp_delta[0][AXIS_Y]);
        check_equal("o_edge_delta1.x", o_edge_delta1[AXIS_X], exp_delta[1][AXIS_X]);
        check_equal("o_edge_delta1.y", o_edge_delta1[AXIS_Y], exp_delta[1][AXIS_Y]);
        check_equal("o_edge_delta2.x", o_edge_delta2[AXIS_X], exp_delta[2][AXIS_X]);
        check_equal("o_edge_delta2.y", o_edge_delta2[AXIS_Y], exp_delta[2][AXIS_Y]);
    endtask

    initial begin
        int   n;
        int   cycles;
        int   hold;
        logic stall;
        lcg_state = 32'd22063;
        rstn      = 1'b0;
        i_dv      = 1'b0;
        i_ready   = 1'b1;
        i_v0      = '{default: '0};
        i_v1      = '{default: '0};
        i_v2      = '{default: '0};
        repeat (RESET_CYCLES) next_cycle();
        rstn = 1'b1;
        next_cycle();
        check_equal("o_ready after reset", o_ready, 1);
        check_equal("o_dv after reset", o_dv, 0);
        check_equal("o_culled after reset", o_culled, 0);
        check_equal("o_area after reset", o_area, 0);

        for (n = 0; n < NUM_TRIS; n++) begin
            make_triangle(n);
            compute_model();
            stall = (next_rand() % 4 == 0);
            hold  = 6 + int'(next_rand() % 10);
            check_equal("o_ready before accept", o_ready, 1);
            i_dv    = 1'b1;
            i_ready = !stall;
            next_cycle();
            i_dv   = 1'b0;
            // Cycle one is the AREA cycle right after the accept edge
            cycles = 1;
            do begin
                next_cycle();
                cycles++;
                if (stall && cycles == hold) i_ready = 1'b1;
                if (!o_dv && !o_culled) begin
                    check_equal("o_ready while busy", o_ready, 0);
                end
            end while (!o_dv && !o_culled);

            check_equal("o_culled", o_culled, exp_culled);
            check_equal("o_ready after result", o_ready, 1);
            if (exp_culled) begin
                check_equal("o_dv on cull", o_dv, 0);
                check_equal("cycles to o_culled", cycles, 3);
            end else begin
                check_equal("cycles to o_dv", cycles, stall ? hold + 1 : 6);
                check_results();
            end
        end

        next_cycle();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_triangle_setup -o tb_triangle_setup_sim

output=$(./obj_dir/tb_triangle_setup_sim 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1

// ==== tb.f ====
+incdir+design
design/raster_fixed_pkg.sv
design/raster_setup_pkg.sv
design/bbox_clamp.sv
design/edge_function_unit.sv
design/setup_sequencer.sv
design/triangle_setup_top.sv
dv/tb_triangle_setup.sv
